/* sim.f */
common/mipsPkg.sv
rtl/decodeController.sv
rtl/registerFile.sv
rtl/branchResolver.sv
rtl/instDecodeStage.sv
sim/tbInstDecode.sv

/* sim/tbInstDecode.sv */
// Decode stage testbench: clock, reset, directed and random stimulus, reference model, checks
`timescale 1ns/1ps

module tbInstDecode;

    localparam int ClockPeriod   = 100;
    localparam int ResetCycles   = 10;
    localparam int DirectedLimit = 40;   // Upper bound on directed cycles
    localparam int RandomCount   = 200;
    localparam int MarginCycles  = 20;
    localparam int WatchdogTime  = (ResetCycles + DirectedLimit + RandomCount + MarginCycles)
                                   * ClockPeriod;

    logic             i_Clock;
    logic             i_rstN;
    mipsPkg::dataWord i_Inst;
    mipsPkg::dataWord i_PCPlus4;
    mipsPkg::regAddr  i_RegWrAddr;
    mipsPkg::dataWord i_RegWrData;
    logic             i_RegWrEnable;
    mipsPkg::dataWord o_DataA;
    mipsPkg::dataWord o_DataB;
    mipsPkg::dataWord o_InstImm;
    mipsPkg::regAddr  o_InstRs;
    mipsPkg::regAddr  o_InstRt;
    mipsPkg::regAddr  o_InstRd;
    logic             o_RegWrEnable;
    logic             o_MemWrEnable;
    logic             o_RegDst;
    logic             o_MemToReg;
    logic             o_AluSrcB;
    mipsPkg::aluCtrl  o_AluControl;
    mipsPkg::dataWord o_JumpAddr;
    logic             o_JumpEnable;

    // Reference model state and expectations
    mipsPkg::dataWord modelRegs [0:31];
    mipsPkg::dataWord expDataA, expDataB, expImm, expJumpAddr;
    mipsPkg::regAddr  expRs, expRt, expRd;
    logic             expRegWr, expMemWr, expRegDst, expMemToReg, expAluSrcB, expJumpEnable;
    mipsPkg::aluCtrl  expAluCtrl;
    logic [9:0]       curCtl;  // alu[9:7] srcB memWr regWr regDst memToReg branch jump
    integer           seed;

    instDecodeStage dut (.*);

    function automatic logic [9:0] decodeControls(input mipsPkg::instOpcode op,
                                                  input mipsPkg::instFunct fn);
        logic            isR;
        logic            fnKnown;
        mipsPkg::aluCtrl alu;
        isR     = (op == mipsPkg::OpRType);
        fnKnown = fn inside {mipsPkg::FnAdd, mipsPkg::FnSub, mipsPkg::FnAnd,
                             mipsPkg::FnOr, mipsPkg::FnSlt};
        alu     = mipsPkg::AluAdd;
        if (op == mipsPkg::OpBeq) alu = mipsPkg::AluSub;
        else if (isR && fn == mipsPkg::FnSub) alu = mipsPkg::AluSub;
        else if (isR && fn == mipsPkg::FnAnd) alu = mipsPkg::AluAnd;
        else if (isR && fn == mipsPkg::FnOr)  alu = mipsPkg::AluOr;
        else if (isR && fn == mipsPkg::FnSlt) alu = mipsPkg::AluSlt;
        return {alu,
                op inside {mipsPkg::OpAddi, mipsPkg::OpLw, mipsPkg::OpSw},
                op == mipsPkg::OpSw,
                (isR && fnKnown) || op == mipsPkg::OpAddi || op == mipsPkg::OpLw,
                isR,
                op == mipsPkg::OpLw,
                op == mipsPkg::OpBeq,
                op == mipsPkg::OpJ};
    endfunction

    function automatic mipsPkg::dataWord modelRead(input mipsPkg::regAddr addr);
        return (addr == '0) ? '0 : modelRegs[addr];
    endfunction

    function automatic mipsPkg::dataWord rType(input int rs, input int rt, input int rd,
                                               input mipsPkg::instFunct fn);
        return {mipsPkg::OpRType, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic mipsPkg::dataWord iType(input mipsPkg::instOpcode op, input int rs,
                                               input int rt, input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] expVal,
                                  input logic [31:0] actVal);
        $display("FAIL time=%0t signal=%s expected=%h actual=%h", $time, name, expVal, actVal);
        $display("Simulation failed");
        $fatal(1, "stopping at first mismatch");
    endtask

    // Drive one instruction and optional write-back on the falling edge
    task automatic presentInst(input mipsPkg::dataWord inst, input mipsPkg::dataWord pc,
                               input logic wrEn, input mipsPkg::regAddr wrAddr,
                               input mipsPkg::dataWord wrData);
        logic [9:0]       ctl;
        mipsPkg::dataWord immExt;
        @(negedge i_Clock);
        i_Inst        = inst;
        i_PCPlus4     = pc;
        i_RegWrEnable = wrEn;
        i_RegWrAddr   = wrAddr;
        i_RegWrData   = wrData;
        ctl           = decodeControls(inst[31:26], inst[5:0]);
        immExt        = {{16{inst[15]}}, inst[15:0]};
        if (ctl[0]) begin
            expJumpAddr   = {pc[31:28], inst[25:0], 2'b00};  // Pseudo-direct
            expJumpEnable = 1'b1;
        end else if (ctl[1]) begin
            expJumpAddr   = pc + (immExt << 2);
            expJumpEnable = (modelRead(inst[25:21]) == modelRead(inst[20:16]));
        end else begin
            expJumpAddr   = '0;
            expJumpEnable = 1'b0;
        end
    endtask

    task automatic issueInst(input mipsPkg::dataWord inst, input mipsPkg::dataWord pc);
        presentInst(inst, pc, 1'b0, '0, '0);
    endtask

    task automatic runRandom();
        mipsPkg::instOpcode ops [0:6];
        mipsPkg::instFunct  fns [0:4];
        mipsPkg::dataWord   fields;
        mipsPkg::dataWord   rnd;
        mipsPkg::dataWord   inst;
        ops = '{mipsPkg::OpRType, mipsPkg::OpJ, mipsPkg::OpBeq, mipsPkg::OpAddi,
                mipsPkg::OpLw, mipsPkg::OpSw, 6'd17};  // Last one unsupported
        fns = '{mipsPkg::FnAdd, mipsPkg::FnSub, mipsPkg::FnAnd, mipsPkg::FnOr, mipsPkg::FnSlt};
        for (int n = 0; n < RandomCount; n++) begin
            fields = $random(seed);
            inst   = {ops[$unsigned($random(seed)) % 7], fields[25:0]};
            if (inst[31:26] == mipsPkg::OpRType) begin
                inst[5:0] = fns[$unsigned($random(seed)) % 5];
            end
            rnd = $random(seed);
            presentInst(inst, $random(seed) & 32'hffff_fffc, rnd[0], rnd[5:1], $random(seed));
        end
    endtask

    assign curCtl = decodeControls(i_Inst[31:26], i_Inst[5:0]);

    // Expected ID/EX contents follow the same edge as the DUT
    always @(posedge i_Clock or negedge i_rstN) begin
        if (!i_rstN) begin
            {expDataA, expDataB, expImm} <= '0;
            {expRs, expRt, expRd}        <= '0;
            {expRegWr, expMemWr, expRegDst, expMemToReg, expAluSrcB} <= '0;
            expAluCtrl <= mipsPkg::AluAdd;
            for (int i = 0; i < 32; i++) begin
                modelRegs[i] <= '0;
            end
        end else begin
            expDataA    <= modelRead(i_Inst[25:21]);  // Value before this edge's write
            expDataB    <= modelRead(i_Inst[20:16]);
            expImm      <= {{16{i_Inst[15]}}, i_Inst[15:0]};
            expRs       <= i_Inst[25:21];
            expRt       <= i_Inst[20:16];
            expRd       <= i_Inst[15:11];
            expAluCtrl  <= curCtl[9:7];
            expAluSrcB  <= curCtl[6];
            expMemWr    <= curCtl[5];
            expRegWr    <= curCtl[4];
            expRegDst   <= curCtl[3];
            expMemToReg <= curCtl[2];
            if (i_RegWrEnable && i_RegWrAddr != '0) begin
                modelRegs[i_RegWrAddr] <= i_RegWrData;
            end
        end
    end

    // Registered outputs sampled mid-cycle
    dataAOk: assert property (@(negedge i_Clock) o_DataA === expDataA)
        else reportMismatch("o_DataA", $sampled(expDataA), $sampled(o_DataA));
    dataBOk: assert property (@(negedge i_Clock) o_DataB === expDataB)
        else reportMismatch("o_DataB", $sampled(expDataB), $sampled(o_DataB));
    immOk: assert property (@(negedge i_Clock) o_InstImm === expImm)
        else reportMismatch("o_InstImm", $sampled(expImm), $sampled(o_InstImm));
    rsOk: assert property (@(negedge i_Clock) o_InstRs === expRs)
        else reportMismatch("o_InstRs", $sampled(expRs), $sampled(o_InstRs));
    rtOk: assert property (@(negedge i_Clock) o_InstRt === expRt)
        else reportMismatch("o_InstRt", $sampled(expRt), $sampled(o_InstRt));
    rdOk: assert property (@(negedge i_Clock) o_InstRd === expRd)
        else reportMismatch("o_InstRd", $sampled(expRd), $sampled(o_InstRd));
    regWrOk: assert property (@(negedge i_Clock) o_RegWrEnable === expRegWr)
        else reportMismatch("o_RegWrEnable", $sampled(expRegWr), $sampled(o_RegWrEnable));
    memWrOk: assert property (@(negedge i_Clock) o_MemWrEnable === expMemWr)
        else reportMismatch("o_MemWrEnable", $sampled(expMemWr), $sampled(o_MemWrEnable));
    regDstOk: assert property (@(negedge i_Clock) o_RegDst === expRegDst)
        else reportMismatch("o_RegDst", $sampled(expRegDst), $sampled(o_RegDst));
    memToRegOk: assert property (@(negedge i_Clock) o_MemToReg === expMemToReg)
        else reportMismatch("o_MemToReg", $sampled(expMemToReg), $sampled(o_MemToReg));
    aluSrcBOk: assert property (@(negedge i_Clock) o_AluSrcB === expAluSrcB)
        else reportMismatch("o_AluSrcB", $sampled(expAluSrcB), $sampled(o_AluSrcB));
    aluCtrlOk: assert property (@(negedge i_Clock) o_AluControl === expAluCtrl)
        else reportMismatch("o_AluControl", $sampled(expAluCtrl), $sampled(o_AluControl));

    // Same-cycle redirect checked before the edge updates the register file
    jumpAddrOk: assert property (@(posedge i_Clock) o_JumpAddr === expJumpAddr)
        else reportMismatch("o_JumpAddr", $sampled(expJumpAddr), $sampled(o_JumpAddr));
    jumpEnOk: assert property (@(posedge i_Clock) o_JumpEnable === expJumpEnable)
        else reportMismatch("o_JumpEnable", $sampled(expJumpEnable), $sampled(o_JumpEnable));

    initial begin
        i_Clock = 1'b0;
        forever #(ClockPeriod / 2) i_Clock = ~i_Clock;
    end

    initial begin
        #(WatchdogTime);
        $display("timeout: stimulus did not finish");
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed          = 32'hab99;
        i_rstN        = 1'b0;
        i_Inst        = '0;
        i_PCPlus4     = '0;
        i_RegWrAddr   = '0;
        i_RegWrData   = '0;
        i_RegWrEnable = 1'b0;
        expJumpAddr   = '0;
        expJumpEnable = 1'b0;
        repeat (ResetCycles) @(posedge i_Clock);
        @(negedge i_Clock);
        i_rstN = 1'b1;

        // Load registers and read two never-written ones
        presentInst(rType(9, 17, 0, mipsPkg::FnAdd), '0, 1'b1, 5'd1, 32'h1111_1111);
        presentInst('0, '0, 1'b1, 5'd2, 32'h2222_2222);
        presentInst('0, '0, 1'b1, 5'd3, 32'h1111_1111);
        presentInst('0, '0, 1'b1, 5'd0, 32'hdead_beef);  // Dropped write to r0
        presentInst('0, '0, 1'b1, 5'd31, 32'h8000_0000);

        // R-type functs plus one unknown
        issueInst(rType(1, 2, 3, mipsPkg::FnAdd), 32'h0040_0000);
        issueInst(rType(3, 0, 4, mipsPkg::FnSub), 32'h0040_0004);
        issueInst(rType(31, 1, 5, mipsPkg::FnAnd), 32'h0040_0008);
        issueInst(rType(2, 31, 6, mipsPkg::FnOr), 32'h0040_000c);
        issueInst(rType(0, 2, 7, mipsPkg::FnSlt), 32'h0040_0010);
        issueInst(rType(1, 3, 8, 6'd7), 32'h0040_0014);

        // I-type with positive and negative immediates
        issueInst(iType(mipsPkg::OpAddi, 1, 5, 16'h1234), 32'h0040_0018);
        issueInst(iType(mipsPkg::OpLw, 2, 6, 16'hfff0), 32'h0040_001c);
        issueInst(iType(mipsPkg::OpSw, 31, 3, 16'h8000), 32'h0040_0020);

        // BEQ taken, not taken, and taken backwards on r0
        issueInst(iType(mipsPkg::OpBeq, 1, 3, 16'h0004), 32'h0040_0024);
        issueInst(iType(mipsPkg::OpBeq, 1, 2, 16'hfffe), 32'h0040_0028);
        issueInst(iType(mipsPkg::OpBeq, 0, 0, 16'hfff8), 32'h0000_1000);

        issueInst({mipsPkg::OpJ, 26'h3ab_cdef}, 32'ha000_0004);
        issueInst({6'd63, 26'h155_aa55}, 32'h0040_0030);  // Unsupported opcode
        issueInst('0, '0);

        runRandom();
        issueInst('0, '0);
        @(negedge i_Clock);  // Last registered check
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* rtl/instDecodeStage.sv */
// Instruction decode stage top: field split, control, registers, branch logic, ID/EX registers
`timescale 1ns/1ps

module instDecodeStage (
    input  logic             i_Clock,
    input  logic             i_rstN,
    input  mipsPkg::dataWord i_Inst,
    input  mipsPkg::dataWord i_PCPlus4,
    input  mipsPkg::regAddr  i_RegWrAddr,    // From write-back
    input  mipsPkg::dataWord i_RegWrData,
    input  logic             i_RegWrEnable,
    output mipsPkg::dataWord o_DataA,
    output mipsPkg::dataWord o_DataB,
    output mipsPkg::dataWord o_InstImm,
    output mipsPkg::regAddr  o_InstRs,
    output mipsPkg::regAddr  o_InstRt,
    output mipsPkg::regAddr  o_InstRd,
    output logic             o_RegWrEnable,
    output logic             o_MemWrEnable,
    output logic             o_RegDst,
    output logic             o_MemToReg,
    output logic             o_AluSrcB,
    output mipsPkg::aluCtrl  o_AluControl,
    output mipsPkg::dataWord o_JumpAddr,     // Same cycle, to fetch
    output logic             o_JumpEnable
);

    // Instruction fields
    mipsPkg::instOpcode                instOp;
    mipsPkg::instFunct                 instFn;
    mipsPkg::regAddr                   instRs;
    mipsPkg::regAddr                   instRt;
    mipsPkg::regAddr                   instRd;
    mipsPkg::dataWord                  instImm;
    logic [mipsPkg::TargetWidth-1:0]   instTarget;

    always_comb begin
        instOp     = i_Inst[31:26];
        instFn     = i_Inst[5:0];
        instRs     = i_Inst[25:21];
        instRt     = i_Inst[20:16];
        instRd     = i_Inst[15:11];
        instImm    = {{(mipsPkg::DataWidth - mipsPkg::ImmWidth){i_Inst[mipsPkg::ImmWidth-1]}},
                      i_Inst[mipsPkg::ImmWidth-1:0]};
        instTarget = i_Inst[mipsPkg::TargetWidth-1:0];
    end

    mipsPkg::aluCtrl  ctrlAluControl;
    logic             ctrlAluSrcB;
    logic             ctrlMemWrEnable;
    logic             ctrlRegWrEnable;
    logic             ctrlRegDst;
    logic             ctrlMemToReg;
    logic             ctrlIsBranch;
    logic             ctrlIsJump;
    mipsPkg::dataWord regDataA;
    mipsPkg::dataWord regDataB;

    decodeController ctrl (
        .i_Clock       (i_Clock),
        .i_rstN        (i_rstN),
        .i_InstOp      (instOp),
        .i_InstFn      (instFn),
        .o_AluControl  (ctrlAluControl),
        .o_AluSrcB     (ctrlAluSrcB),
        .o_MemWrEnable (ctrlMemWrEnable),
        .o_RegWrEnable (ctrlRegWrEnable),
        .o_RegDst      (ctrlRegDst),
        .o_MemToReg    (ctrlMemToReg),
        .o_IsBranch    (ctrlIsBranch),
        .o_IsJump      (ctrlIsJump)
    );

    registerFile regs (
        .i_Clock    (i_Clock),
        .i_rstN     (i_rstN),
        .i_WrEnable (i_RegWrEnable),
        .i_WrAddr   (i_RegWrAddr),
        .i_RdAddrA  (instRs),
        .i_RdAddrB  (instRt),
        .i_WrData   (i_RegWrData),
        .o_RdDataA  (regDataA),
        .o_RdDataB  (regDataB)
    );

    branchResolver branch (
        .i_IsBranch   (ctrlIsBranch),
        .i_IsJump     (ctrlIsJump),
        .i_PCPlus4    (i_PCPlus4),
        .i_InstImm    (instImm),
        .i_DataA      (regDataA),
        .i_DataB      (regDataB),
        .i_InstTarget (instTarget),
        .o_JumpAddr   (o_JumpAddr),
        .o_JumpEnable (o_JumpEnable)
    );

    // ID/EX pipeline registers
    always_ff @(posedge i_Clock or negedge i_rstN) begin
        if (!i_rstN) begin
            o_DataA       <= '0;
            o_DataB       <= '0;
            o_InstImm     <= '0;
            o_InstRs      <= '0;
            o_InstRt      <= '0;
            o_InstRd      <= '0;
            o_RegWrEnable <= 1'b0;
            o_MemWrEnable <= 1'b0;
            o_RegDst      <= 1'b0;
            o_MemToReg    <= 1'b0;
            o_AluSrcB     <= 1'b0;
            o_AluControl  <= mipsPkg::AluAdd;
        end else begin
            o_DataA       <= regDataA;
            o_DataB       <= regDataB;
            o_InstImm     <= instImm;
            o_InstRs      <= instRs;   // Kept for forwarding in EX
            o_InstRt      <= instRt;
            o_InstRd      <= instRd;
            o_RegWrEnable <= ctrlRegWrEnable;
            o_MemWrEnable <= ctrlMemWrEnable;
            o_RegDst      <= ctrlRegDst;
            o_MemToReg    <= ctrlMemToReg;
            o_AluSrcB     <= ctrlAluSrcB;
            o_AluControl  <= ctrlAluControl;
        end
    end

endmodule

/* rtl/branchResolver.sv */
// Early BEQ and J resolution: operand compare, target adder and target select
`timescale 1ns/1ps

module branchResolver (
    input  logic                               i_IsBranch,
    input  logic                               i_IsJump,
    input  mipsPkg::dataWord                   i_PCPlus4,
    input  mipsPkg::dataWord                   i_InstImm,     // Already sign-extended
    input  mipsPkg::dataWord                   i_DataA,
    input  mipsPkg::dataWord                   i_DataB,
    input  logic [mipsPkg::TargetWidth-1:0]    i_InstTarget,
    output mipsPkg::dataWord                   o_JumpAddr,
    output logic                               o_JumpEnable
);

    logic             operandsEqual;
    mipsPkg::dataWord branchTarget;
    mipsPkg::dataWord jumpTarget;

    always_comb begin
        operandsEqual = (i_DataA == i_DataB);

        // PC-relative word offset
        branchTarget = i_PCPlus4 + {i_InstImm[mipsPkg::DataWidth-3:0], 2'b00};

        // Pseudo-direct target stays in the current 256 MB region
        jumpTarget = {i_PCPlus4[mipsPkg::DataWidth-1 -: 4], i_InstTarget, 2'b00};

        if (i_IsJump) begin
            o_JumpAddr = jumpTarget;
        end else if (i_IsBranch) begin
            o_JumpAddr = branchTarget;
        end else begin
            o_JumpAddr = '0;
        end

        o_JumpEnable = i_IsJump | (i_IsBranch & operandsEqual);
    end

endmodule

/* rtl/registerFile.sv */
// 32-entry general purpose register file, two async reads and one clocked write
`timescale 1ns/1ps

module registerFile (
    input  logic             i_Clock,
    input  logic             i_rstN,
    input  logic             i_WrEnable,
    input  mipsPkg::regAddr  i_WrAddr,
    input  mipsPkg::regAddr  i_RdAddrA,
    input  mipsPkg::regAddr  i_RdAddrB,
    input  mipsPkg::dataWord i_WrData,
    output mipsPkg::dataWord o_RdDataA,
    output mipsPkg::dataWord o_RdDataB
);

    mipsPkg::dataWord regs [0:mipsPkg::RegCount-1];

    always_ff @(posedge i_Clock or negedge i_rstN) begin
        if (!i_rstN) begin
            for (int i = 0; i < mipsPkg::RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (i_WrEnable && (i_WrAddr != '0)) begin
            regs[i_WrAddr] <= i_WrData;  // r0 never written
        end
    end

    // Read ports with r0 forced to zero
    always_comb begin
        o_RdDataA = (i_RdAddrA == '0) ? '0 : regs[i_RdAddrA];
        o_RdDataB = (i_RdAddrB == '0) ? '0 : regs[i_RdAddrB];
    end

    // Write-back must present a clean index whenever it writes
    wrAddrKnown: assert property (
        @(posedge i_Clock) disable iff (!i_rstN)
        i_WrEnable |-> !$isunknown(i_WrAddr)
    ) else $error("registerFile: write enabled with unknown address");

endmodule

/* rtl/decodeController.sv */
// Opcode and funct decode table driving the datapath control bits
`timescale 1ns/1ps

module decodeController (
    input  logic               i_Clock,        // Only samples the assertion
    input  logic               i_rstN,
    input  mipsPkg::instOpcode i_InstOp,
    input  mipsPkg::instFunct  i_InstFn,
    output mipsPkg::aluCtrl    o_AluControl,
    output logic               o_AluSrcB,      // Immediate as ALU operand B
    output logic               o_MemWrEnable,
    output logic               o_RegWrEnable,
    output logic               o_RegDst,       // Destination is rd, not rt
    output logic               o_MemToReg,
    output logic               o_IsBranch,
    output logic               o_IsJump
);

    always_comb begin
        // Everything low unless the opcode says otherwise
        o_AluControl  = mipsPkg::AluAdd;
        o_AluSrcB     = 1'b0;
        o_MemWrEnable = 1'b0;
        o_RegWrEnable = 1'b0;
        o_RegDst      = 1'b0;
        o_MemToReg    = 1'b0;
        o_IsBranch    = 1'b0;
        o_IsJump      = 1'b0;

        case (i_InstOp)
            mipsPkg::OpRType: begin
                o_RegDst      = 1'b1;
                o_RegWrEnable = 1'b1;
                case (i_InstFn)
                    mipsPkg::FnAdd: o_AluControl = mipsPkg::AluAdd;
                    mipsPkg::FnSub: o_AluControl = mipsPkg::AluSub;
                    mipsPkg::FnAnd: o_AluControl = mipsPkg::AluAnd;
                    mipsPkg::FnOr:  o_AluControl = mipsPkg::AluOr;
                    mipsPkg::FnSlt: o_AluControl = mipsPkg::AluSlt;
                    default: begin
                        // Unknown funct keeps only RegDst
                        o_RegWrEnable = 1'b0;
                    end
                endcase
            end

            mipsPkg::OpAddi: begin
                o_RegWrEnable = 1'b1;
                o_AluSrcB     = 1'b1;
                o_AluControl  = mipsPkg::AluAdd;
            end

            mipsPkg::OpLw: begin
                o_RegWrEnable = 1'b1;
                o_AluSrcB     = 1'b1;          // Base plus offset
                o_MemToReg    = 1'b1;
                o_AluControl  = mipsPkg::AluAdd;
            end

            mipsPkg::OpSw: begin
                o_MemWrEnable = 1'b1;
                o_AluSrcB     = 1'b1;
                o_AluControl  = mipsPkg::AluAdd;
            end

            mipsPkg::OpBeq: begin
                o_IsBranch   = 1'b1;
                o_AluControl = mipsPkg::AluSub;  // Compare by subtraction in EX
            end

            mipsPkg::OpJ: begin
                o_IsJump = 1'b1;
            end

            default: begin
                // Unsupported opcode behaves as a no-op
            end
        endcase
    end

    // Fetch hands over a bubble as a real no-op, never as an unknown word
    opcodeKnown: assert property (
        @(posedge i_Clock) disable iff (!i_rstN)
        !$isunknown(i_InstOp)
    ) else $error("decodeController: unknown opcode bits out of reset");

endmodule

/* common/mipsPkg.sv */
// Shared widths, vector types, opcode, funct and ALU control codes for the decode stage
package mipsPkg;

    // Field and word widths
    localparam int DataWidth    = 32;
    localparam int RegAddrWidth = 5;
    localparam int OpcodeWidth  = 6;
    localparam int FunctWidth   = 6;
    localparam int AluCtrlWidth = 3;
    localparam int ImmWidth     = 16;  // Low half-word of I-type
    localparam int TargetWidth  = 26;  // Pseudo-direct J target
    localparam int RegCount     = 2 ** RegAddrWidth;

    typedef logic [DataWidth-1:0]    dataWord;
    typedef logic [RegAddrWidth-1:0] regAddr;
    typedef logic [OpcodeWidth-1:0]  instOpcode;
    typedef logic [FunctWidth-1:0]   instFunct;
    typedef logic [AluCtrlWidth-1:0] aluCtrl;

    // Primary opcodes in instruction bits 31:26
    localparam instOpcode OpRType = 6'd0;
    localparam instOpcode OpJ     = 6'd2;
    localparam instOpcode OpBeq   = 6'd4;
    localparam instOpcode OpAddi  = 6'd8;
    localparam instOpcode OpLw    = 6'd35;
    localparam instOpcode OpSw    = 6'd43;

    // R-type funct codes in instruction bits 5:0
    localparam instFunct FnAdd = 6'd32;
    localparam instFunct FnSub = 6'd34;
    localparam instFunct FnAnd = 6'd36;
    localparam instFunct FnOr  = 6'd37;
    localparam instFunct FnSlt = 6'd42;

    // Operation codes seen by the execute stage ALU
    localparam aluCtrl AluAdd = 3'd0;  // Also the idle value
    localparam aluCtrl AluSub = 3'd1;
    localparam aluCtrl AluAnd = 3'd2;
    localparam aluCtrl AluOr  = 3'd3;
    localparam aluCtrl AluSlt = 3'd4;

endpackage
